//--- src/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Instruction and address width
`define FETCH_XLEN 32

// Instruction memory size in words
// Byte address bits above bit 1 index it, modulo the depth
`define IMEM_DEPTH 256

// Entries in the fetch queue
`define FETCH_QUEUE_DEPTH 4

// Occupancy counter width
// Wide enough to hold a completely full queue
`define FETCH_COUNT_W ($clog2(`FETCH_QUEUE_DEPTH + 1))

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

//--- src/fetchPkg.sv
`include "fetch_defines.svh"

package fetchPkg;

    // Predecode result for one fetched word
    // Only plain words reach the instruction queue
    typedef enum logic [1:0] {
        CLS_PLAIN  = 2'b00,
        CLS_BRANCH = 2'b01,
        CLS_NOP    = 2'b10
    } instrClass_t;

    // Queue payload, the instruction word tagged with its own address
    typedef struct packed {
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] instr;
    } fetchEntry_t;

endpackage

//--- src/instrMem.sv
`include "fetch_defines.svh"

module instrMem (
    input  logic                   clk,
    input  logic                   memRe,
    input  logic [`FETCH_XLEN-1:0] memAddr,
    output logic [`FETCH_XLEN-1:0] memData,
    input  logic                   progWe,
    input  logic [`FETCH_XLEN-1:0] progAddr,
    input  logic [`FETCH_XLEN-1:0] progData
);

    localparam int AW = $clog2(`IMEM_DEPTH);

    logic [`FETCH_XLEN-1:0] mem [`IMEM_DEPTH];

    // Word index from a byte address
    logic [AW-1:0] rdIdx;
    logic [AW-1:0] wrIdx;

    assign rdIdx = memAddr[AW+1:2];
    assign wrIdx = progAddr[AW+1:2];

    // Program port, loaded while the core sits in reset
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[wrIdx] <= progData;
        end
    end

    // Registered read, data is valid the cycle after memRe
    always_ff @(posedge clk) begin
        if (memRe) begin
            memData <= mem[rdIdx];
        end
    end

endmodule

//--- src/branchPredecode.sv
`include "fetch_defines.svh"

module branchPredecode (
    input  logic [`FETCH_XLEN-1:0] instr,
    input  logic [`FETCH_XLEN-1:0] pc,
    output fetchPkg::instrClass_t  instrClass,
    output logic [`FETCH_XLEN-1:0] branchTarget
);

    // Major opcode field and sub-opcode used for B and NOP
    logic [1:0] majorOp;
    logic [3:0] subOp;

    // Branch displacement in words
    logic [15:0] imm16;
    logic [`FETCH_XLEN-1:0] byteOffset;

    assign majorOp = instr[31:30];
    assign subOp   = instr[28:25];
    assign imm16   = instr[15:0];

    // Sign extend and scale to bytes
    assign byteOffset = {{(`FETCH_XLEN - 18){imm16[15]}}, imm16, 2'b00};

    // Relative to the word after the branch
    assign branchTarget = pc + `FETCH_XLEN'(4) + byteOffset;

    always_comb begin
        instrClass = fetchPkg::CLS_PLAIN;
        if (majorOp == 2'b11) begin
            case (subOp)
                4'b0000: instrClass = fetchPkg::CLS_BRANCH;
                4'b0010: instrClass = fetchPkg::CLS_NOP;
                default: instrClass = fetchPkg::CLS_PLAIN;
            endcase
        end
    end

endmodule

//--- src/fetchUnit.sv
`include "fetch_defines.svh"

module fetchUnit (
    input  logic                      clk,
    input  logic                      rst,
    output logic [`FETCH_XLEN-1:0]    memAddr,
    output logic                      memRe,
    input  logic [`FETCH_XLEN-1:0]    memData,
    input  logic [`FETCH_COUNT_W-1:0] count,
    input  fetchPkg::instrClass_t     instrClass,
    input  logic [`FETCH_XLEN-1:0]    branchTarget,
    output logic [`FETCH_XLEN-1:0]    predecodeInstr,
    output logic [`FETCH_XLEN-1:0]    predecodePc,
    output logic                      enq,
    output fetchPkg::fetchEntry_t     enqEntry
);

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t state;

    // Address of the next read to issue
    logic [`FETCH_XLEN-1:0] issuePc;

    // A read was issued last cycle and its word is on memData now
    logic inFlight;
    logic [`FETCH_XLEN-1:0] inFlightPc;

    // The word returning now is a wrong-path sequential fetch
    logic squash;

    logic liveReturn;
    logic redirect;

    // Keep one slot free for the word already in flight
    assign memRe   = (state == S_RUN) && (int'(count) < `FETCH_QUEUE_DEPTH - 1);
    assign memAddr = issuePc;

    // Predecoder looks at whatever comes back this cycle
    assign predecodeInstr = memData;
    assign predecodePc    = inFlightPc;

    assign liveReturn = inFlight && !squash;
    assign redirect   = liveReturn && (instrClass == fetchPkg::CLS_BRANCH);

    // NOPs and branches die here
    assign enq = liveReturn && (instrClass == fetchPkg::CLS_PLAIN);

    assign enqEntry.pc    = inFlightPc;
    assign enqEntry.instr = memData;

    // Sequencer control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            issuePc  <= `RESET_PC;
            inFlight <= 1'b0;
            squash   <= 1'b0;
        end else begin
            // One idle cycle out of reset, then fetch continuously
            if (state == S_IDLE) begin
                state <= S_RUN;
            end

            inFlight <= memRe;

            // The read issued alongside a taken branch is the sequential word
            squash <= redirect && memRe;

            if (redirect) begin
                issuePc <= branchTarget;
            end else if (memRe) begin
                issuePc <= issuePc + `FETCH_XLEN'(4);
            end
        end
    end

    // Tag for the returning word
    always_ff @(posedge clk) begin
        if (memRe) begin
            inFlightPc <= issuePc;
        end
    end

    // Issue throttling must keep the queue from ever overflowing
    enqBelowFull: assert property (
        @(posedge clk) disable iff (rst)
        enq |-> (int'(count) != `FETCH_QUEUE_DEPTH)
    ) else $error("fetchUnit: enqueue while queue is full");

    // Taken branches must land on a word boundary
    redirectAligned: assert property (
        @(posedge clk) disable iff (rst)
        redirect |=> (issuePc[1:0] == 2'b00)
    ) else $error("fetchUnit: redirect to unaligned address %h", issuePc);

endmodule

//--- src/fetchQueue.sv
module fetchQueue #(
    parameter type entryT = logic [63:0],
    parameter int  DEPTH  = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enq,
    input  entryT                          enqEntry,
    input  logic                           hold,
    output logic                           outValid,
    output entryT                          outEntry,
    output logic [$clog2(DEPTH + 1) - 1:0] count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    entryT buffer [DEPTH];

    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic pop;

    // Advance with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] result;
        if (int'(ptr) == DEPTH - 1) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // Head goes out whenever the consumer is not holding
    assign outValid = (count != '0) && !hold;
    assign pop      = outValid;
    assign outEntry = buffer[rdPtr];

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({enq, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (enq) begin
            buffer[wrPtr] <= enqEntry;
        end
    end

    // The producer is expected to watch count and never push into a full queue
    noEnqWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        enq |-> (int'(count) < DEPTH)
    ) else $error("fetchQueue: enqueue while full");

endmodule

//--- src/fetchTop.sv
`include "fetch_defines.svh"

module fetchTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   progWe,
    input  logic [`FETCH_XLEN-1:0] progAddr,
    input  logic [`FETCH_XLEN-1:0] progData,
    input  logic                   hold,
    output logic                   outValid,
    output logic [`FETCH_XLEN-1:0] outPc,
    output logic [`FETCH_XLEN-1:0] outInstr
);

    // Memory port
    logic [`FETCH_XLEN-1:0] memAddr;
    logic                   memRe;
    logic [`FETCH_XLEN-1:0] memData;

    // Predecode path
    logic [`FETCH_XLEN-1:0] predecodeInstr;
    logic [`FETCH_XLEN-1:0] predecodePc;
    fetchPkg::instrClass_t  instrClass;
    logic [`FETCH_XLEN-1:0] branchTarget;

    // Queue side
    logic                      enq;
    fetchPkg::fetchEntry_t     enqEntry;
    fetchPkg::fetchEntry_t     outEntry;
    logic [`FETCH_COUNT_W-1:0] count;

    instrMem u_instrMem (
        .clk      (clk),
        .memRe    (memRe),
        .memAddr  (memAddr),
        .memData  (memData),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData)
    );

    branchPredecode u_branchPredecode (
        .instr        (predecodeInstr),
        .pc           (predecodePc),
        .instrClass   (instrClass),
        .branchTarget (branchTarget)
    );

    fetchUnit u_fetchUnit (
        .clk            (clk),
        .rst            (rst),
        .memAddr        (memAddr),
        .memRe          (memRe),
        .memData        (memData),
        .count          (count),
        .instrClass     (instrClass),
        .branchTarget   (branchTarget),
        .predecodeInstr (predecodeInstr),
        .predecodePc    (predecodePc),
        .enq            (enq),
        .enqEntry       (enqEntry)
    );

    fetchQueue #(
        .entryT (fetchPkg::fetchEntry_t),
        .DEPTH  (`FETCH_QUEUE_DEPTH)
    ) u_fetchQueue (
        .clk      (clk),
        .rst      (rst),
        .enq      (enq),
        .enqEntry (enqEntry),
        .hold     (hold),
        .outValid (outValid),
        .outEntry (outEntry),
        .count    (count)
    );

    assign outPc    = outEntry.pc;
    assign outInstr = outEntry.instr;

endmodule

//--- verif/fetchTb.sv
`include "fetch_defines.svh"

module fetchTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS   = 5;
    localparam int MAX_BEATS   = 16;
    localparam int WAIT_LIMIT  = 400;
    localparam int SETTLE      = 20;
    localparam int WATCHDOG_NS = NUM_TESTS * MAX_BEATS * 20 * 8;

    localparam logic [`FETCH_XLEN-1:0] NOP_WORD = 32'hC400_0000;

    logic                   clk;
    logic                   rst;
    logic                   progWe;
    logic [`FETCH_XLEN-1:0] progAddr;
    logic [`FETCH_XLEN-1:0] progData;
    logic                   hold;
    logic                   outValid;
    logic [`FETCH_XLEN-1:0] outPc;
    logic [`FETCH_XLEN-1:0] outInstr;

    // Program image, expected stream and observed stream
    logic [`FETCH_XLEN-1:0] prog[$];
    fetchPkg::fetchEntry_t  expected[$];
    fetchPkg::fetchEntry_t  got[$];

    int seed;
    int entryErrors;
    int quietErrors;
    int otherErrors;

    fetchTop u_fetchTop (
        .clk      (clk),
        .rst      (rst),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .hold     (hold),
        .outValid (outValid),
        .outPc    (outPc),
        .outInstr (outInstr)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Every delivered beat in order
    always @(posedge clk) begin
        if (!rst && outValid) begin
            got.push_back(fetchPkg::fetchEntry_t'({outPc, outInstr}));
        end
    end

    // Instruction encodings
    function automatic logic [`FETCH_XLEN-1:0] plainWord(input logic [15:0] tag);
        return {16'h0A00, tag};
    endfunction

    // Major opcode 11 but a sub-opcode that is neither B nor NOP
    function automatic logic [`FETCH_XLEN-1:0] plainHigh(input logic [15:0] tag);
        return {16'hC200, tag};
    endfunction

    function automatic logic [`FETCH_XLEN-1:0] branchTo(input logic [`FETCH_XLEN-1:0] from,
                                                         input logic [`FETCH_XLEN-1:0] to);
        logic [`FETCH_XLEN-1:0] diff;
        diff = to - from - 32'd4;
        return {16'hC000, diff[17:2]};
    endfunction

    function automatic fetchPkg::instrClass_t classifyWord(input logic [`FETCH_XLEN-1:0] w);
        fetchPkg::instrClass_t cls;
        cls = fetchPkg::CLS_PLAIN;
        if (w[31:30] == 2'b11 && w[28:25] == 4'b0000) begin
            cls = fetchPkg::CLS_BRANCH;
        end else if (w[31:30] == 2'b11 && w[28:25] == 4'b0010) begin
            cls = fetchPkg::CLS_NOP;
        end
        return cls;
    endfunction

    // Signed word displacement counted from the word after the branch
    function automatic logic [`FETCH_XLEN-1:0] targetOf(input logic [`FETCH_XLEN-1:0] pc,
                                                         input logic [`FETCH_XLEN-1:0] w);
        int words;
        words = $signed(w[15:0]);
        words = words + 1;
        return pc + 32'(words * 4);
    endfunction

    // Walk the program from the reset PC
    // A branch to itself ends the walk
    task automatic buildModel(input int maxBeats);
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] w;
        logic [`FETCH_XLEN-1:0] tgt;
        fetchPkg::fetchEntry_t  e;
        int idx;
        int steps;
        bit halted;
        expected.delete();
        pc = `RESET_PC;
        halted = 1'b0;
        steps = 0;
        while (!halted && expected.size() < maxBeats && steps < 1000) begin
            idx = int'(pc >> 2) % `IMEM_DEPTH;
            w = (idx < prog.size()) ? prog[idx] : '0;
            case (classifyWord(w))
                fetchPkg::CLS_BRANCH: begin
                    tgt = targetOf(pc, w);
                    if (tgt == pc) begin
                        halted = 1'b1;
                    end else begin
                        pc = tgt;
                    end
                end
                fetchPkg::CLS_NOP: pc = pc + 32'd4;
                default: begin
                    e.pc = pc;
                    e.instr = w;
                    expected.push_back(e);
                    pc = pc + 32'd4;
                end
            endcase
            steps++;
        end
    endtask

    task automatic checkEntry(input fetchPkg::fetchEntry_t actual,
                              input fetchPkg::fetchEntry_t exp, input int idx);
        if (actual !== exp) begin
            $display("[FAIL] t=%0t beat %0d: pc %h instr %h, expected pc %h instr %h",
                     $time, idx, actual.pc, actual.instr, exp.pc, exp.instr);
            entryErrors++;
        end
    endtask

    task automatic checkQuiet(input logic valid);
        if (valid !== 1'b0) begin
            $display("[FAIL] t=%0t outValid is %b while rst is high", $time, valid);
            quietErrors++;
        end
    endtask

    task automatic quietWindow(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            checkQuiet(outValid);
        end
    endtask

    // Core sits in reset while the program goes in
    task automatic loadProgram();
        @(posedge clk);
        rst <= 1'b1;
        hold <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            checkQuiet(outValid);
            progWe <= 1'b1;
            progAddr <= 32'(i) << 2;
            progData <= prog[i];
        end
        @(posedge clk);
        checkQuiet(outValid);
        progWe <= 1'b0;
        got.delete();
        rst <= 1'b0;
    endtask

    // Wait until n beats have been delivered
    task automatic waitBeats(input int n, input bit randomHold);
        int cycles;
        int r;
        cycles = 0;
        while (cycles < WAIT_LIMIT && got.size() < n) begin
            @(posedge clk);
            if (randomHold) begin
                r = $random(seed);
                hold <= (r[1:0] != 2'b00);
            end
            @(negedge clk);
            cycles++;
        end
        if (got.size() < n) begin
            $display("Timed out after %0d cycles with %0d of %0d beats delivered",
                     cycles, got.size(), n);
            otherErrors++;
        end
        if (randomHold) begin
            @(posedge clk);
            hold <= 1'b0;
        end
    endtask

    task automatic compareStream(input bit strict);
        int n;
        if (strict) begin
            repeat (SETTLE) @(negedge clk);
            if (got.size() != expected.size()) begin
                $display("Stream length wrong at t=%0t: %0d beats delivered, %0d expected",
                         $time, got.size(), expected.size());
                otherErrors++;
            end
        end
        n = (got.size() < expected.size()) ? got.size() : expected.size();
        for (int i = 0; i < n; i++) begin
            checkEntry(got[i], expected[i], i);
        end
    endtask

    task automatic runProgram(input int maxBeats, input bit strict, input bit randomHold);
        loadProgram();
        buildModel(maxBeats);
        waitBeats(expected.size(), randomHold);
        compareStream(strict);
    endtask

    task automatic testStraightLine();
        $display("Test: straight-line code");
        prog.delete();
        for (int i = 0; i < 10; i++) begin
            prog.push_back((i == 6) ? plainHigh(16'(i)) : plainWord(16'h0100 + 16'(i)));
        end
        prog.push_back(branchTo(32'd40, 32'd40));
        runProgram(MAX_BEATS, 1'b1, 1'b0);
    endtask

    task automatic testBranches();
        $display("Test: forward and backward branches");
        prog.delete();
        prog.push_back(plainWord(16'h0200));
        prog.push_back(branchTo(32'd4, 32'd24));
        prog.push_back(plainWord(16'h0202));
        prog.push_back(plainWord(16'h0203));
        prog.push_back(branchTo(32'd16, 32'd16));
        prog.push_back(plainWord(16'h0205));
        prog.push_back(plainHigh(16'h0206));
        prog.push_back(branchTo(32'd28, 32'd12));
        prog.push_back(plainWord(16'h0208));
        runProgram(MAX_BEATS, 1'b1, 1'b0);

        // Endless backward loop checked for its first 12 beats
        prog.delete();
        for (int i = 0; i < 4; i++) begin
            prog.push_back(plainWord(16'h0300 + 16'(i)));
        end
        prog.push_back(branchTo(32'd16, 32'd4));
        runProgram(12, 1'b0, 1'b0);
    endtask

    task automatic testNopRemoval();
        $display("Test: NOP removal");
        prog.delete();
        prog.push_back(plainWord(16'h0400));
        prog.push_back(NOP_WORD);
        prog.push_back(branchTo(32'd8, 32'd20));
        prog.push_back(NOP_WORD);
        prog.push_back(plainWord(16'h0404));
        prog.push_back(NOP_WORD);
        prog.push_back(plainWord(16'h0406));
        prog.push_back(NOP_WORD);
        prog.push_back(NOP_WORD);
        prog.push_back(plainHigh(16'h0409));
        prog.push_back(branchTo(32'd40, 32'd40));
        runProgram(MAX_BEATS, 1'b1, 1'b0);
    endtask

    task automatic testBackPressure();
        $display("Test: back-pressure with random hold");
        prog.delete();
        for (int i = 0; i < 6; i++) begin
            prog.push_back(plainWord(16'h0500 + 16'(i)));
        end
        prog.push_back(branchTo(32'd24, 32'd32));
        prog.push_back(plainWord(16'h0507));
        for (int i = 8; i < 12; i++) begin
            prog.push_back(plainWord(16'h0500 + 16'(i)));
        end
        prog.push_back(NOP_WORD);
        prog.push_back(plainHigh(16'h050D));
        prog.push_back(branchTo(32'd56, 32'd56));
        runProgram(MAX_BEATS, 1'b1, 1'b1);
    endtask

    task automatic testMidRunReset();
        $display("Test: reset in the middle of a run");
        prog.delete();
        for (int i = 0; i < 8; i++) begin
            prog.push_back(plainWord(16'h0600 + 16'(i)));
        end
        prog.push_back(branchTo(32'd32, 32'd32));
        loadProgram();
        buildModel(MAX_BEATS);
        waitBeats(3, 1'b0);
        compareStream(1'b0);

        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        quietWindow(4);
        @(posedge clk);
        checkQuiet(outValid);
        got.delete();
        rst <= 1'b0;

        // Delivery starts over from the reset PC
        waitBeats(expected.size(), 1'b0);
        compareStream(1'b1);
    endtask

    initial begin
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        hold = 1'b0;
        seed = 28657;
        entryErrors = 0;
        quietErrors = 0;
        otherErrors = 0;
        repeat (2) @(posedge clk);

        testStraightLine();
        testBranches();
        testNopRemoval();
        testBackPressure();
        testMidRunReset();

        $display("Errors: %0d entry, %0d quiet, %0d other",
                 entryErrors, quietErrors, otherErrors);
        if (entryErrors + quietErrors + otherErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+src
src/fetchPkg.sv
src/instrMem.sv
src/branchPredecode.sv
src/fetchUnit.sv
src/fetchQueue.sv
src/fetchTop.sv
verif/fetchTb.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module fetchTb \
    -o fetchSim

./obj_dir/fetchSim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
